//--- source/cam_pkg.sv
package cam_pkg;

    // Basic data widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] count_t;
    typedef logic [7:0]  opcode_t;

    // Command set
    localparam opcode_t OP_CAPTURE         = 8'h20;
    localparam opcode_t OP_BYTES_AVAILABLE = 8'h21;
    localparam opcode_t OP_READ_DATA       = 8'h22;
    localparam opcode_t OP_ZOOM            = 8'h23;
    localparam opcode_t OP_PAN             = 8'h24;
    localparam opcode_t OP_METERING        = 8'h25;

    // Capture memory
    localparam int FRAME_DEPTH     = 256;
    localparam int FRAME_ADDR_BITS = $clog2(FRAME_DEPTH);

    // Flops on each SPI pin before use
    localparam int RESET_SYNC_STAGES = 2;

    // SPI frame sequencing
    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_OPCODE,
        LINK_DATA
    } link_state_t;

endpackage

//--- source/spi_link.sv
`timescale 1ns/1ps

module spi_link
    import cam_pkg::*;
(
    input  logic    clock_in,
    input  logic    reset_n_in,
    input  logic    sclk,
    input  logic    cs_n,
    input  logic    mosi,
    output logic    miso,
    output opcode_t op_code,
    output logic    op_code_valid,
    output byte_t   operand,
    output logic    operand_valid,
    output count_t  operand_count,
    input  byte_t   response,
    input  logic    response_valid
);

    logic [RESET_SYNC_STAGES-1:0] sclk_sync;
    logic [RESET_SYNC_STAGES-1:0] cs_n_sync;
    logic [RESET_SYNC_STAGES-1:0] mosi_sync;
    logic        sclk_prev;
    logic        sclk_s;
    logic        cs_n_s;
    logic        mosi_s;
    logic        sclk_rise;
    logic        sclk_fall;
    logic        byte_done;
    link_state_t state;
    logic [2:0]  bit_count;
    logic [1:0]  load_timer;
    byte_t       rx_shift;
    byte_t       rx_byte;
    byte_t       tx_shift;

    assign sclk_s    = sclk_sync[RESET_SYNC_STAGES-1];
    assign cs_n_s    = cs_n_sync[RESET_SYNC_STAGES-1];
    assign mosi_s    = mosi_sync[RESET_SYNC_STAGES-1];
    assign sclk_rise = sclk_s & ~sclk_prev;
    assign sclk_fall = ~sclk_s & sclk_prev;
    assign rx_byte   = {rx_shift[6:0], mosi_s};
    assign byte_done = sclk_rise && (bit_count == 3'd7) && (state != LINK_IDLE);
    assign miso      = tx_shift[7];

    // Pin synchronizers with chip select idling high
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            sclk_sync <= '0;
            cs_n_sync <= '1;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[RESET_SYNC_STAGES-2:0], sclk};
            cs_n_sync <= {cs_n_sync[RESET_SYNC_STAGES-2:0], cs_n};
            mosi_sync <= {mosi_sync[RESET_SYNC_STAGES-2:0], mosi};
            sclk_prev <= sclk_s;
        end
    end

    always_ff @(posedge clock_in) begin
        if (sclk_rise) begin
            rx_shift <= rx_byte;
        end
        if (byte_done && state == LINK_DATA) begin
            operand <= rx_byte;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state         <= LINK_IDLE;
            bit_count     <= '0;
            load_timer    <= '0;
            tx_shift      <= '0;
            op_code       <= '0;
            op_code_valid <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= '0;
        end else if (cs_n_s) begin
            state         <= LINK_IDLE;
            bit_count     <= '0;
            load_timer    <= '0;
            tx_shift      <= '0;
            op_code_valid <= 1'b0;
            operand_valid <= 1'b0;
        end else begin
            operand_valid <= 1'b0;
            if (load_timer != 2'd0) begin
                load_timer <= load_timer - 2'd1;
            end
            if (sclk_rise && state != LINK_IDLE) begin
                bit_count <= bit_count + 3'd1;
            end

            case (state)
                LINK_IDLE: begin
                    // Command byte shifts out zeros
                    state     <= LINK_OPCODE;
                    bit_count <= '0;
                    tx_shift  <= '0;
                end
                LINK_OPCODE: begin
                    if (byte_done) begin
                        op_code       <= rx_byte;
                        op_code_valid <= 1'b1;
                        operand_count <= '0;
                        load_timer    <= 2'd3;
                        state         <= LINK_DATA;
                    end
                end
                LINK_DATA: begin
                    if (byte_done) begin
                        operand_valid <= 1'b1;
                        operand_count <= operand_count + count_t'(1);
                        load_timer    <= 2'd3;
                    end
                end
                default: begin
                    state <= LINK_IDLE;
                end
            endcase

            // Load lands 3 cycles after the byte boundary
            if (load_timer == 2'd1) begin
                tx_shift <= response_valid ? response : '0;
            end else if (sclk_fall && bit_count != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        operand_valid |-> op_code_valid);

endmodule

//--- source/spi_registers.sv
`timescale 1ns/1ps

module spi_registers
    import cam_pkg::*;
(
    input  logic    clock_in,
    input  logic    reset_n_in,
    input  opcode_t op_code,
    input  logic    op_code_valid,
    input  byte_t   operand,
    input  logic    operand_valid,
    input  count_t  operand_count,
    output byte_t   response,
    output logic    response_valid,
    output logic    start_capture,
    input  count_t  bytes_available,
    input  byte_t   data,
    output count_t  bytes_read,
    input  byte_t   red_peak,
    input  byte_t   green_peak,
    input  byte_t   blue_peak
);

    count_t     bytes_remaining;
    logic [1:0] valid_monitor;
    logic       read_frame_end;

    assign bytes_remaining = bytes_available - bytes_read;

    // Falling edge of op_code_valid closes a read frame
    assign read_frame_end = (valid_monitor == 2'b10) && (op_code == OP_READ_DATA);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            response       <= '0;
            response_valid <= 1'b0;
            start_capture  <= 1'b0;
            bytes_read     <= '0;
            valid_monitor  <= '0;
        end else begin
            valid_monitor <= {valid_monitor[0], op_code_valid};

            if (op_code_valid) begin
                case (op_code)
                    OP_CAPTURE: begin
                        start_capture  <= 1'b1;
                        bytes_read     <= '0;
                        response_valid <= 1'b0;
                    end
                    OP_BYTES_AVAILABLE: begin
                        case (operand_count)
                            count_t'(0): begin
                                response       <= bytes_remaining[15:8];
                                response_valid <= 1'b1;
                            end
                            count_t'(1): begin
                                response       <= bytes_remaining[7:0];
                                response_valid <= 1'b1;
                            end
                            default: begin
                                response_valid <= 1'b0;
                            end
                        endcase
                    end
                    OP_READ_DATA: begin
                        response       <= data;
                        response_valid <= 1'b1;
                    end
                    OP_METERING: begin
                        case (operand_count)
                            count_t'(0): begin
                                response       <= red_peak;
                                response_valid <= 1'b1;
                            end
                            count_t'(1): begin
                                response       <= green_peak;
                                response_valid <= 1'b1;
                            end
                            count_t'(2): begin
                                response       <= blue_peak;
                                response_valid <= 1'b1;
                            end
                            default: begin
                                response_valid <= 1'b0;
                            end
                        endcase
                    end
                    // Accepted and ignored along with any operands
                    OP_ZOOM, OP_PAN: begin
                        response_valid <= 1'b0;
                    end
                    default: begin
                        response_valid <= 1'b0;
                    end
                endcase
            end else begin
                response_valid <= 1'b0;
                start_capture  <= 1'b0;
                if (read_frame_end && bytes_read < bytes_available) begin
                    bytes_read <= bytes_read + count_t'(1);
                end
            end
        end
    end

    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        bytes_read <= bytes_available);

endmodule

//--- source/frame_store.sv
`timescale 1ns/1ps

module frame_store
    import cam_pkg::*;
(
    input  logic   clock_in,
    input  logic   reset_n_in,
    input  logic   start_capture,
    input  byte_t  pixel,
    input  logic   pixel_valid,
    input  count_t bytes_read,
    output count_t bytes_available,
    output byte_t  data
);

    byte_t                      mem [FRAME_DEPTH];
    logic                       store_pixel;
    logic [FRAME_ADDR_BITS-1:0] read_addr;
    count_t                     last_addr;

    assign store_pixel = pixel_valid && !start_capture &&
                         (bytes_available < count_t'(FRAME_DEPTH));
    assign last_addr   = bytes_available - count_t'(1);

    // Past the end, keep serving the last stored byte
    always_comb begin
        if (bytes_read < bytes_available) begin
            read_addr = bytes_read[FRAME_ADDR_BITS-1:0];
        end else if (bytes_available != '0) begin
            read_addr = last_addr[FRAME_ADDR_BITS-1:0];
        end else begin
            read_addr = '0;
        end
    end

    assign data = mem[read_addr];

    // Write pointer doubles as the byte count
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            bytes_available <= '0;
        end else if (start_capture) begin
            bytes_available <= '0;
        end else if (store_pixel) begin
            bytes_available <= bytes_available + count_t'(1);
        end
    end

    always_ff @(posedge clock_in) begin
        if (store_pixel) begin
            mem[bytes_available[FRAME_ADDR_BITS-1:0]] <= pixel;
        end
    end

    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        bytes_available <= count_t'(FRAME_DEPTH));

endmodule

//--- source/peak_metering.sv
`timescale 1ns/1ps

module peak_metering
    import cam_pkg::*;
(
    input  logic  clock_in,
    input  logic  reset_n_in,
    input  logic  start_capture,
    input  byte_t pixel,
    input  logic  pixel_valid,
    output byte_t red_peak,
    output byte_t green_peak,
    output byte_t blue_peak
);

    byte_t      pixel_q;
    logic       pixel_valid_q;
    logic [1:0] channel;

    always_ff @(posedge clock_in) begin
        pixel_q <= pixel;
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in || start_capture) begin
            pixel_valid_q <= 1'b0;
            channel       <= 2'd0;
            red_peak      <= '0;
            green_peak    <= '0;
            blue_peak     <= '0;
        end else begin
            pixel_valid_q <= pixel_valid;
            if (pixel_valid_q) begin
                case (channel)
                    2'd0: begin
                        if (pixel_q > red_peak) begin
                            red_peak <= pixel_q;
                        end
                    end
                    2'd1: begin
                        if (pixel_q > green_peak) begin
                            green_peak <= pixel_q;
                        end
                    end
                    default: begin
                        if (pixel_q > blue_peak) begin
                            blue_peak <= pixel_q;
                        end
                    end
                endcase
                // R, G, B then wrap
                channel <= (channel == 2'd2) ? 2'd0 : channel + 2'd1;
            end
        end
    end

endmodule

//--- source/camera_spi_top.sv
`timescale 1ns/1ps

module camera_spi_top
    import cam_pkg::*;
(
    input  logic  clock_in,
    input  logic  reset_n_in,
    input  logic  sclk,
    input  logic  cs_n,
    input  logic  mosi,
    output logic  miso,
    input  byte_t pixel,
    input  logic  pixel_valid
);

    opcode_t op_code;
    logic    op_code_valid;
    byte_t   operand;
    logic    operand_valid;
    count_t  operand_count;
    byte_t   response;
    logic    response_valid;
    logic    start_capture;
    count_t  bytes_read;
    count_t  bytes_available;
    byte_t   data;
    byte_t   red_peak;
    byte_t   green_peak;
    byte_t   blue_peak;

    spi_link link (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .sclk           (sclk),
        .cs_n           (cs_n),
        .mosi           (mosi),
        .miso           (miso),
        .op_code        (op_code),
        .op_code_valid  (op_code_valid),
        .operand        (operand),
        .operand_valid  (operand_valid),
        .operand_count  (operand_count),
        .response       (response),
        .response_valid (response_valid)
    );

    spi_registers registers (
        .clock_in        (clock_in),
        .reset_n_in      (reset_n_in),
        .op_code         (op_code),
        .op_code_valid   (op_code_valid),
        .operand         (operand),
        .operand_valid   (operand_valid),
        .operand_count   (operand_count),
        .response        (response),
        .response_valid  (response_valid),
        .start_capture   (start_capture),
        .bytes_available (bytes_available),
        .data            (data),
        .bytes_read      (bytes_read),
        .red_peak        (red_peak),
        .green_peak      (green_peak),
        .blue_peak       (blue_peak)
    );

    frame_store store (
        .clock_in        (clock_in),
        .reset_n_in      (reset_n_in),
        .start_capture   (start_capture),
        .pixel           (pixel),
        .pixel_valid     (pixel_valid),
        .bytes_read      (bytes_read),
        .bytes_available (bytes_available),
        .data            (data)
    );

    peak_metering metering (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .start_capture (start_capture),
        .pixel         (pixel),
        .pixel_valid   (pixel_valid),
        .red_peak      (red_peak),
        .green_peak    (green_peak),
        .blue_peak     (blue_peak)
    );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock_in,
    output logic reset_n_in
);

    localparam int RESET_CYCLES = 10;

    // 40 ns period
    initial begin
        clock_in = 1'b0;
        forever #20 clock_in = ~clock_in;
    end

    initial begin
        reset_n_in = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_in);
        @(negedge clock_in);
        reset_n_in = 1'b1;
    end

endmodule

//--- tests/response_checker.sv
`timescale 1ns/1ps

module response_checker
    import cam_pkg::*;
(
    input  logic  clock_in,
    input  logic  sclk,
    input  logic  cs_n,
    input  logic  miso,
    input  byte_t exp_byte,
    input  logic  exp_strobe,
    input  logic  test_done,
    input  int    test_id,
    output int    error_count,
    output int    passed_tests,
    output int    failed_tests
);

    byte_t expected_q [$];
    byte_t shift = '0;
    byte_t want = '0;
    int    bit_count = 0;
    int    errors = 0;
    int    errors_at_start = 0;
    int    passed = 0;
    int    failed = 0;
    logic  sclk_q = 1'b0;

    assign error_count  = errors;
    assign passed_tests = passed;
    assign failed_tests = failed;

    // sclk only moves on falling clock edges, so it is stable here
    always @(posedge clock_in) begin
        if (exp_strobe) begin
            expected_q.push_back(exp_byte);
        end

        if (cs_n) begin
            bit_count = 0;
        end else if (sclk && !sclk_q) begin
            shift = {shift[6:0], miso};
            bit_count = bit_count + 1;
            if (bit_count == 8) begin
                bit_count = 0;
                if (expected_q.size() == 0) begin
                    $display("error at %0t ns: miso returned 0x%02h with no byte expected",
                             $time, shift);
                    errors = errors + 1;
                end else begin
                    want = expected_q.pop_front();
                    if (shift !== want) begin
                        $display("mismatch at %0t ns: miso expected 0x%02h, got 0x%02h",
                                 $time, want, shift);
                        errors = errors + 1;
                    end
                end
            end
        end
        sclk_q = sclk;

        if (test_done) begin
            if (expected_q.size() != 0) begin
                $display("test %0d: %0d expected bytes were never shifted out on miso",
                         test_id, expected_q.size());
                errors = errors + expected_q.size();
                expected_q.delete();
            end
            if (errors == errors_at_start) begin
                passed = passed + 1;
                $display("test %0d: pass", test_id);
            end else begin
                failed = failed + 1;
                $display("test %0d: fail with %0d errors", test_id, errors - errors_at_start);
            end
            errors_at_start = errors;
        end
    end

endmodule

//--- tests/tb_camera_spi.sv
`timescale 1ns/1ps

module tb_camera_spi
    import cam_pkg::*;
();

    localparam int  SPI_HALF     = 8;
    localparam int  FRAME_GAP    = 16;
    localparam real CLOCK_PERIOD = 40.0;

    localparam int ACT_CAPTURE = 0;
    localparam int ACT_AVAIL   = 1;
    localparam int ACT_READ    = 2;
    localparam int ACT_METER   = 3;
    localparam int ACT_ZOOM    = 4;
    localparam int ACT_PAN     = 5;

    logic        clock_in;
    logic        reset_n_in;
    logic        sclk;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    byte_t       pixel;
    logic        pixel_valid;
    byte_t       exp_byte;
    logic        exp_strobe;
    logic        test_done;
    int          test_id;
    int          error_count;
    int          passed_tests;
    int          failed_tests;

    // Stimulus table, one entry per test
    int          step_action [$];
    int          step_count [$];
    int          step_expect [$];

    // Reference model of the capture store and meters
    byte_t       stored [$];
    byte_t       peak [3];
    int          read_ptr;
    int          pixel_index;
    logic [31:0] lfsr_state;

    clock_gen clocks (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in)
    );

    camera_spi_top uut (
        .clock_in    (clock_in),
        .reset_n_in  (reset_n_in),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .miso        (miso),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    response_checker monitor (
        .clock_in     (clock_in),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .miso         (miso),
        .exp_byte     (exp_byte),
        .exp_strobe   (exp_strobe),
        .test_done    (test_done),
        .test_id      (test_id),
        .error_count  (error_count),
        .passed_tests (passed_tests),
        .failed_tests (failed_tests)
    );

    task automatic add_step(input int action, input int count, input int expected);
        step_action.push_back(action);
        step_count.push_back(count);
        step_expect.push_back(expected);
    endtask

    task automatic build_table();
        add_step(ACT_AVAIL, 0, 0);
        add_step(ACT_METER, 0, 0);
        add_step(ACT_CAPTURE, 10, 0);
        add_step(ACT_AVAIL, 0, 10);
        add_step(ACT_READ, 10, 0);
        // Past the end
        add_step(ACT_READ, 2, 0);
        add_step(ACT_AVAIL, 0, 0);
        add_step(ACT_CAPTURE, 30, 0);
        add_step(ACT_METER, 0, 0);
        add_step(ACT_ZOOM, 0, 0);
        add_step(ACT_PAN, 0, 0);
        add_step(ACT_AVAIL, 0, 30);
        add_step(ACT_READ, 3, 0);
        add_step(ACT_CAPTURE, 300, 0);
        add_step(ACT_AVAIL, 0, 256);
        add_step(ACT_METER, 0, 0);
        add_step(ACT_CAPTURE, 0, 0);
        add_step(ACT_AVAIL, 0, 0);
        add_step(ACT_METER, 0, 0);
    endtask

    // SPI bytes plus pixel bytes over the whole table
    function automatic int table_bytes();
        int total;
        int i;
        total = 0;
        for (i = 0; i < step_action.size(); i++) begin
            case (step_action[i])
                ACT_CAPTURE: total = total + 1 + step_count[i];
                ACT_READ:    total = total + 5 * step_count[i];
                ACT_METER:   total = total + 4;
                default:     total = total + 3;
            endcase
        end
        return total;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_pixel(output byte_t value);
        int k;
        value = '0;
        for (k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic push_expected(input byte_t value);
        exp_byte = value;
        exp_strobe = 1'b1;
        @(negedge clock_in);
        exp_strobe = 1'b0;
    endtask

    // Mode 0, MSB first
    task automatic spi_byte(input byte_t value);
        int b;
        for (b = 7; b >= 0; b--) begin
            mosi = value[b];
            repeat (SPI_HALF) @(negedge clock_in);
            sclk = 1'b1;
            repeat (SPI_HALF) @(negedge clock_in);
            sclk = 1'b0;
        end
    endtask

    task automatic spi_frame(input byte_t command, input int operands, input byte_t value);
        int i;
        cs_n = 1'b0;
        spi_byte(command);
        for (i = 0; i < operands; i++) begin
            spi_byte(value);
        end
        repeat (SPI_HALF) @(negedge clock_in);
        cs_n = 1'b1;
        repeat (FRAME_GAP) @(negedge clock_in);
    endtask

    task automatic drive_pixels(input int count);
        byte_t value;
        int    i;
        for (i = 0; i < count; i++) begin
            random_pixel(value);
            pixel = value;
            pixel_valid = 1'b1;
            @(negedge clock_in);
            if (stored.size() < FRAME_DEPTH) begin
                stored.push_back(value);
            end
            if (value > peak[pixel_index % 3]) begin
                peak[pixel_index % 3] = value;
            end
            pixel_index = pixel_index + 1;
        end
        pixel_valid = 1'b0;
        repeat (4) @(negedge clock_in);
    endtask

    task automatic capture_frame(input int count);
        push_expected(8'h00);
        spi_frame(OP_CAPTURE, 0, 8'h00);
        stored.delete();
        read_ptr = 0;
        pixel_index = 0;
        peak[0] = '0;
        peak[1] = '0;
        peak[2] = '0;
        repeat (4) @(negedge clock_in);
        drive_pixels(count);
    endtask

    task automatic query_available(input int expected);
        count_t remaining;
        remaining = count_t'(expected);
        push_expected(8'h00);
        push_expected(remaining[15:8]);
        push_expected(remaining[7:0]);
        spi_frame(OP_BYTES_AVAILABLE, 2, 8'h00);
    endtask

    task automatic query_metering();
        push_expected(8'h00);
        push_expected(peak[0]);
        push_expected(peak[1]);
        push_expected(peak[2]);
        spi_frame(OP_METERING, 3, 8'h00);
    endtask

    task automatic read_bytes(input int count);
        byte_t value;
        int    i;
        for (i = 0; i < count; i++) begin
            if (read_ptr < stored.size()) begin
                value = stored[read_ptr];
            end else begin
                value = stored[stored.size() - 1];
            end
            push_expected(8'h00);
            push_expected(value);
            spi_frame(OP_READ_DATA, 1, 8'h00);
            if (read_ptr < stored.size()) begin
                read_ptr = read_ptr + 1;
            end
            query_available(stored.size() - read_ptr);
        end
    endtask

    task automatic ignored_command(input byte_t command);
        push_expected(8'h00);
        push_expected(8'h00);
        push_expected(8'h00);
        spi_frame(command, 2, 8'h5a);
    endtask

    task automatic mark_test_done(input int id);
        test_id = id;
        test_done = 1'b1;
        @(negedge clock_in);
        test_done = 1'b0;
    endtask

    initial begin
        int i;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        pixel = '0;
        pixel_valid = 1'b0;
        exp_byte = '0;
        exp_strobe = 1'b0;
        test_done = 1'b0;
        test_id = 0;
        read_ptr = 0;
        pixel_index = 0;
        peak[0] = '0;
        peak[1] = '0;
        peak[2] = '0;
        lfsr_state = 32'h8d67_6b10;
        build_table();

        @(posedge reset_n_in);
        repeat (4) @(negedge clock_in);
        for (i = 0; i < step_action.size(); i++) begin
            case (step_action[i])
                ACT_CAPTURE: capture_frame(step_count[i]);
                ACT_AVAIL:   query_available(step_expect[i]);
                ACT_READ:    read_bytes(step_count[i]);
                ACT_METER:   query_metering();
                ACT_ZOOM:    ignored_command(OP_ZOOM);
                default:     ignored_command(OP_PAN);
            endcase
            mark_test_done(i);
        end
        repeat (4) @(negedge clock_in);

        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 step_action.size(), passed_tests, failed_tests, error_count);
        if (error_count == 0 && failed_tests == 0 && passed_tests == step_action.size()) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Twice the time the table needs at full SPI speed
    initial begin
        real limit;
        @(posedge reset_n_in);
        limit = table_bytes() * 16.0 * SPI_HALF * CLOCK_PERIOD * 2.0;
        #(limit);
        $display("watchdog: run did not finish within %0.0f ns of reset release", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- flist.f
source/cam_pkg.sv
source/spi_link.sv
source/spi_registers.sv
source/frame_store.sv
source/peak_metering.sv
source/camera_spi_top.sv
tests/clock_gen.sv
tests/response_checker.sv
tests/tb_camera_spi.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_camera_spi -f flist.f -o sim_camera
	@out="$$(./obj_dir/sim_camera)"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
